//--- rtl/CorePkg.sv
`default_nettype none

package CorePkg;

    // reorder buffer slots run 1..RobEntries, so tag 0 can mean "value ready"
    localparam int RobEntries = 15;
    localparam int TagBits = 4;

    typedef logic [TagBits-1:0] RobTag;
    typedef logic [4:0] RegNm;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASSB
    } AluOp;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
    } FetchPacket;

    typedef struct packed {
        AluOp op;
        RegNm rs1;
        RegNm rs2;
        RegNm rd;
        logic [31:0] imm;
        logic pcA;
        logic immB;
        logic illegal;
    } DecodedOp;

    // nonzero tag means the operand still waits for that ROB entry
    typedef struct packed {
        logic [31:0] value;
        RobTag tag;
    } Operand;

    typedef struct packed {
        AluOp op;
        Operand srcA;
        Operand srcB;
        RobTag tagDst;
    } IssueOp;

    typedef struct packed {
        logic valid;
        AluOp op;
        logic [31:0] a;
        logic [31:0] b;
        RobTag tagDst;
    } AluReq;

    typedef struct packed {
        logic valid;
        RobTag tag;
        logic [31:0] value;
    } ResultBus;

    typedef struct packed {
        RegNm regNm;
        logic [31:0] value;
        logic [31:0] pc;
        logic illegal;
    } CommitPacket;

endpackage

`default_nettype wire

//--- rtl/InstrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module InstrDecoder (
    input wire [31:0] instr,
    input wire [31:0] pc,
    output CorePkg::DecodedOp decoded
);

    // illegal ops run through an ALU as PASSB of zero and write no register
    localparam CorePkg::DecodedOp IllegalOp = '{
        op: CorePkg::PASSB,
        rs1: '0,
        rs2: '0,
        rd: '0,
        imm: '0,
        pcA: 1'b0,
        immB: 1'b1,
        illegal: 1'b1
    };

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [31:0] immI;
    logic opLegal;
    logic immLegal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign immI = {{20{instr[31]}}, instr[31:20]};

    // SUB and SRA are the only OP encodings with funct7 bit 5 set
    assign opLegal = (funct7 == 7'b0000000)
        || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign immLegal = (funct3 == 3'b001) ? (funct7 == 7'b0000000)
        : (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000)
        : 1'b1;

    function automatic CorePkg::AluOp aluFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: return alt ? CorePkg::SUB : CorePkg::ADD;
            3'b001: return CorePkg::SLL;
            3'b010: return CorePkg::SLT;
            3'b011: return CorePkg::SLTU;
            3'b100: return CorePkg::XOR;
            3'b101: return alt ? CorePkg::SRA : CorePkg::SRL;
            3'b110: return CorePkg::OR;
            default: return CorePkg::AND;
        endcase
    endfunction

    always_comb begin
        decoded = IllegalOp;
        case (opcode)
            7'b0110011: begin
                if (opLegal) begin
                    decoded.op = aluFunct(funct3, funct7[5]);
                    decoded.rs1 = instr[19:15];
                    decoded.rs2 = instr[24:20];
                    decoded.rd = instr[11:7];
                    decoded.immB = 1'b0;
                    decoded.illegal = 1'b0;
                end
            end
            7'b0010011: begin
                if (immLegal) begin
                    // addi never turns into a subtract
                    decoded.op = aluFunct(funct3, funct3 == 3'b101 && funct7[5]);
                    decoded.rs1 = instr[19:15];
                    decoded.rd = instr[11:7];
                    decoded.imm = immI;
                    decoded.illegal = 1'b0;
                end
            end
            7'b0110111: begin
                decoded.op = CorePkg::PASSB;
                decoded.rd = instr[11:7];
                decoded.imm = {instr[31:12], 12'b0};
                decoded.illegal = 1'b0;
            end
            7'b0010111: begin
                decoded.op = CorePkg::ADD;
                decoded.rd = instr[11:7];
                decoded.imm = {instr[31:12], 12'b0};
                decoded.pcA = 1'b1;
                decoded.illegal = 1'b0;
            end
            default: ;
        endcase
        // misaligned fetch address
        if (pc[1:0] != 2'b00) begin
            decoded = IllegalOp;
        end
    end

endmodule

`default_nettype wire

//--- rtl/RenameTable.sv
`timescale 1ns/1ps
`default_nettype none

module RenameTable (
    input wire clk,
    input wire rst,
    input wire CorePkg::RegNm rdRegNm [2],
    output CorePkg::Operand rdValue [2],
    input wire allocValid,
    input wire CorePkg::RegNm allocReg,
    input wire CorePkg::RobTag allocTag,
    input wire commitValid,
    input wire CorePkg::CommitPacket commit,
    input wire CorePkg::RobTag commitTag
);

    logic [31:0] regValue [32];
    CorePkg::RobTag regTag [32];

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            // x0 is always a ready zero
            if (rdRegNm[k] == '0) begin
                rdValue[k] = '0;
            end else begin
                rdValue[k] = '{value: regValue[rdRegNm[k]], tag: regTag[rdRegNm[k]]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                regValue[r] <= '0;
                regTag[r] <= '0;
            end
        end else begin
            if (commitValid && commit.regNm != '0) begin
                regValue[commit.regNm] <= commit.value;
                // a newer producer keeps its tag
                if (regTag[commit.regNm] == commitTag) begin
                    regTag[commit.regNm] <= '0;
                end
            end
            // allocation comes last so it wins over a same-cycle commit
            if (allocValid && allocReg != '0) begin
                regTag[allocReg] <= allocTag;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/DecodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeStage #(
    parameter int NumAlus = 2
) (
    input wire clk,
    input wire rst,
    input wire CorePkg::FetchPacket fetch,
    input wire instrReq,
    output logic instrAck,
    input wire rsFull,
    input wire robFull,
    input wire CorePkg::ResultBus result [NumAlus],
    input wire CorePkg::Operand robLookup [2],
    output CorePkg::RobTag lookupTag [2],
    input wire CorePkg::RobTag tagDst,
    output logic dispatchValid,
    output CorePkg::IssueOp dispatch,
    output CorePkg::CommitPacket robInfo,
    input wire commitValid,
    input wire CorePkg::CommitPacket commit,
    input wire CorePkg::RobTag commitTag
);

    CorePkg::DecodedOp decoded;
    CorePkg::RegNm srcReg [2];
    CorePkg::Operand renValue [2];
    logic accept;

    // one instruction per four-phase handshake, held off while RS or ROB is full
    assign accept = instrReq && !instrAck && !rsFull && !robFull;
    assign dispatchValid = accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            instrAck <= 1'b0;
        end else if (accept) begin
            instrAck <= 1'b1;
        end else if (!instrReq) begin
            instrAck <= 1'b0;
        end
    end

    assign srcReg[0] = decoded.rs1;
    assign srcReg[1] = decoded.rs2;
    assign lookupTag[0] = renValue[0].tag;
    assign lookupTag[1] = renValue[1].tag;

    // rename value, then ROB value, then a result landing this very cycle
    function automatic CorePkg::Operand pickOperand(
        input CorePkg::Operand ren,
        input CorePkg::Operand rob
    );
        CorePkg::Operand res;
        if (ren.tag == '0) begin
            res = ren;
        end else if (rob.tag == '0) begin
            res = rob;
        end else begin
            res = ren;
            for (int l = 0; l < NumAlus; l++) begin
                if (result[l].valid && result[l].tag == ren.tag) begin
                    res = '{value: result[l].value, tag: '0};
                end
            end
        end
        return res;
    endfunction

    always_comb begin
        dispatch.op = decoded.op;
        dispatch.tagDst = tagDst;
        if (decoded.pcA) begin
            dispatch.srcA = '{value: fetch.pc, tag: '0};
        end else begin
            dispatch.srcA = pickOperand(renValue[0], robLookup[0]);
        end
        if (decoded.immB) begin
            dispatch.srcB = '{value: decoded.imm, tag: '0};
        end else begin
            dispatch.srcB = pickOperand(renValue[1], robLookup[1]);
        end
    end

    assign robInfo = '{
        regNm: decoded.rd,
        value: '0,
        pc: fetch.pc,
        illegal: decoded.illegal
    };

    InstrDecoder decoder (
        .instr(fetch.instr),
        .pc(fetch.pc),
        .decoded(decoded)
    );

    RenameTable rat (
        .clk(clk),
        .rst(rst),
        .rdRegNm(srcReg),
        .rdValue(renValue),
        .allocValid(accept && decoded.rd != '0 && !decoded.illegal),
        .allocReg(decoded.rd),
        .allocTag(tagDst),
        .commitValid(commitValid),
        .commit(commit),
        .commitTag(commitTag)
    );

endmodule

`default_nettype wire

//--- rtl/ReservationStation.sv
`timescale 1ns/1ps
`default_nettype none

module ReservationStation #(
    parameter int NumAlus = 2,
    parameter int RsDepth = 4
) (
    input wire clk,
    input wire rst,
    input wire dispatchValid,
    input wire CorePkg::IssueOp dispatch,
    input wire CorePkg::ResultBus result [NumAlus],
    output CorePkg::AluReq issue [NumAlus],
    output logic rsFull
);

    logic [RsDepth-1:0] valid;
    logic [RsDepth-1:0] ready;
    logic [RsDepth-1:0] grant;
    logic [RsDepth-1:0] freeSel;
    CorePkg::IssueOp entry [RsDepth];

    assign rsFull = &valid;

    // captures a broadcast value for a waiting operand
    function automatic CorePkg::Operand wake(input CorePkg::Operand src);
        CorePkg::Operand res;
        res = src;
        for (int l = 0; l < NumAlus; l++) begin
            if (result[l].valid && src.tag != '0 && result[l].tag == src.tag) begin
                res = '{value: result[l].value, tag: '0};
            end
        end
        return res;
    endfunction

    always_comb begin
        freeSel = '0;
        for (int e = 0; e < RsDepth; e++) begin
            ready[e] = entry[e].srcA.tag == '0 && entry[e].srcB.tag == '0;
            if (!valid[e] && freeSel == '0) begin
                freeSel[e] = 1'b1;
            end
        end
    end

    // lane i takes the i-th lowest ready entry
    always_comb begin
        int lane;
        lane = 0;
        grant = '0;
        for (int i = 0; i < NumAlus; i++) begin
            issue[i] = '0;
        end
        for (int e = 0; e < RsDepth; e++) begin
            if (valid[e] && ready[e] && lane < NumAlus) begin
                issue[lane] = '{
                    valid: 1'b1,
                    op: entry[e].op,
                    a: entry[e].srcA.value,
                    b: entry[e].srcB.value,
                    tagDst: entry[e].tagDst
                };
                grant[e] = 1'b1;
                lane++;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~grant) | (dispatchValid ? freeSel : '0);
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < RsDepth; e++) begin
            if (dispatchValid && freeSel[e]) begin
                entry[e] <= dispatch;
            end else begin
                entry[e].srcA <= wake(entry[e].srcA);
                entry[e].srcB <= wake(entry[e].srcB);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/IntAlu.sv
`timescale 1ns/1ps
`default_nettype none

module IntAlu (
    input wire clk,
    input wire rst,
    input wire CorePkg::AluReq req,
    output CorePkg::ResultBus result
);

    logic [31:0] aluValue;
    logic [4:0] shamt;

    assign shamt = req.b[4:0];

    always_comb begin
        case (req.op)
            CorePkg::ADD: aluValue = req.a + req.b;
            CorePkg::SUB: aluValue = req.a - req.b;
            CorePkg::SLL: aluValue = req.a << shamt;
            CorePkg::SLT: aluValue = {31'b0, $signed(req.a) < $signed(req.b)};
            CorePkg::SLTU: aluValue = {31'b0, req.a < req.b};
            CorePkg::XOR: aluValue = req.a ^ req.b;
            CorePkg::SRL: aluValue = req.a >> shamt;
            CorePkg::SRA: aluValue = $unsigned($signed(req.a) >>> shamt);
            CorePkg::OR: aluValue = req.a | req.b;
            CorePkg::AND: aluValue = req.a & req.b;
            default: aluValue = req.b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= req.valid;
        end
        result.tag <= req.tagDst;
        result.value <= aluValue;
    end

endmodule

`default_nettype wire

//--- rtl/ReorderBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module ReorderBuffer #(
    parameter int NumAlus = 2
) (
    input wire clk,
    input wire rst,
    input wire allocValid,
    input wire CorePkg::CommitPacket allocInfo,
    output CorePkg::RobTag allocTag,
    output logic robFull,
    input wire CorePkg::ResultBus result [NumAlus],
    input wire CorePkg::RobTag lookupTag [2],
    output CorePkg::Operand lookup [2],
    output logic commitValid,
    output CorePkg::CommitPacket commit,
    output CorePkg::RobTag commitTag
);

    CorePkg::CommitPacket info [1:CorePkg::RobEntries];
    logic [CorePkg::RobEntries:1] done;
    CorePkg::RobTag head;
    CorePkg::RobTag tail;
    logic [CorePkg::TagBits-1:0] count;
    logic allocDo;

    // slot 0 is skipped so the wrap goes from the last slot back to 1
    function automatic CorePkg::RobTag nextTag(input CorePkg::RobTag t);
        return (t == CorePkg::RobTag'(CorePkg::RobEntries)) ? CorePkg::RobTag'(1) : t + 1'b1;
    endfunction

    assign allocTag = tail;
    assign robFull = count == CorePkg::RobTag'(CorePkg::RobEntries);
    assign allocDo = allocValid && !robFull;

    assign commitValid = done[head];
    assign commit = info[head];
    assign commitTag = head;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            if (lookupTag[k] != '0 && done[lookupTag[k]]) begin
                lookup[k] = '{value: info[lookupTag[k]].value, tag: '0};
            end else begin
                lookup[k] = '{value: '0, tag: lookupTag[k]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= CorePkg::RobTag'(1);
            tail <= CorePkg::RobTag'(1);
            count <= '0;
            done <= '0;
        end else begin
            for (int l = 0; l < NumAlus; l++) begin
                if (result[l].valid) begin
                    done[result[l].tag] <= 1'b1;
                end
            end
            if (allocDo) begin
                tail <= nextTag(tail);
            end
            if (commitValid) begin
                done[head] <= 1'b0;
                head <= nextTag(head);
            end
            case ({allocDo, commitValid})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (allocDo) begin
            info[tail] <= allocInfo;
        end
        for (int l = 0; l < NumAlus; l++) begin
            if (result[l].valid) begin
                info[result[l].tag].value <= result[l].value;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/OooCore.sv
`timescale 1ns/1ps
`default_nettype none

module OooCore #(
    parameter int NumAlus = 2,
    parameter int RsDepth = 4
) (
    input wire clk,
    input wire rst,
    input wire CorePkg::FetchPacket fetch,
    input wire instrReq,
    output logic instrAck,
    output logic commitValid,
    output CorePkg::CommitPacket commit
);

    CorePkg::ResultBus result [NumAlus];
    CorePkg::AluReq issue [NumAlus];
    CorePkg::Operand robLookup [2];
    CorePkg::RobTag lookupTag [2];
    CorePkg::RobTag tagDst;
    CorePkg::RobTag commitTag;
    CorePkg::IssueOp dispatch;
    CorePkg::CommitPacket robInfo;
    logic dispatchValid;
    logic rsFull;
    logic robFull;

    DecodeStage #(.NumAlus(NumAlus)) decode (
        .clk(clk),
        .rst(rst),
        .fetch(fetch),
        .instrReq(instrReq),
        .instrAck(instrAck),
        .rsFull(rsFull),
        .robFull(robFull),
        .result(result),
        .robLookup(robLookup),
        .lookupTag(lookupTag),
        .tagDst(tagDst),
        .dispatchValid(dispatchValid),
        .dispatch(dispatch),
        .robInfo(robInfo),
        .commitValid(commitValid),
        .commit(commit),
        .commitTag(commitTag)
    );

    ReservationStation #(.NumAlus(NumAlus), .RsDepth(RsDepth)) rs (
        .clk(clk),
        .rst(rst),
        .dispatchValid(dispatchValid),
        .dispatch(dispatch),
        .result(result),
        .issue(issue),
        .rsFull(rsFull)
    );

    for (genvar i = 0; i < NumAlus; i++) begin : gAlu
        IntAlu alu (
            .clk(clk),
            .rst(rst),
            .req(issue[i]),
            .result(result[i])
        );
    end

    ReorderBuffer #(.NumAlus(NumAlus)) rob (
        .clk(clk),
        .rst(rst),
        .allocValid(dispatchValid),
        .allocInfo(robInfo),
        .allocTag(tagDst),
        .robFull(robFull),
        .result(result),
        .lookupTag(lookupTag),
        .lookup(robLookup),
        .commitValid(commitValid),
        .commit(commit),
        .commitTag(commitTag)
    );

endmodule

`default_nettype wire

//--- bench/OooCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module OooCoreTb;

    localparam int ResetCycles = 10;
    localparam int CyclesPerInstr = 200;

    logic clk;
    logic rst;
    CorePkg::FetchPacket fetch;
    logic instrReq;
    logic instrAck;
    logic commitValid;
    CorePkg::CommitPacket commit;

    logic [31:0] lfsr;
    logic [31:0] pcNext;
    logic [31:0] modelRegs [32];
    CorePkg::CommitPacket expectQ [$];
    int sentCount = 0;

    OooCore #(.NumAlus(2), .RsDepth(4)) uut (
        .clk(clk),
        .rst(rst),
        .fetch(fetch),
        .instrReq(instrReq),
        .instrAck(instrAck),
        .commitValid(commitValid),
        .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            failRun("handshake signal has the wrong level");
        end
    endtask

    task automatic compareCommit(input CorePkg::CommitPacket got,
        input CorePkg::CommitPacket exp);
        if (got !== exp) begin
            $write("MISMATCH at %0t: commit got rd=%0d value=%h pc=%h illegal=%b",
                $time, got.regNm, got.value, got.pc, got.illegal);
            $display(" expected rd=%0d value=%h pc=%h illegal=%b",
                exp.regNm, exp.value, exp.pc, exp.illegal);
            failRun("commit does not match the reference model");
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
    task automatic takeBits(input int n, output logic [31:0] bits);
        logic fb;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
    endtask

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] uType(input logic [6:0] opc, input logic [19:0] imm,
        input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    // rv32 integer semantics with the shift amount from the low five bits
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic CorePkg::CommitPacket modelExec(input logic [31:0] instr,
        input logic [31:0] pc);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [31:0] b;
        logic [31:0] res;
        logic legal;
        logic alt;
        opc = instr[6:0];
        f3 = instr[14:12];
        f7 = instr[31:25];
        b = modelRegs[instr[24:20]];
        res = '0;
        legal = 1'b0;
        alt = 1'b0;
        case (opc)
            7'b0110011: begin
                legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                alt = f7[5];
                res = aluRef(f3, alt, modelRegs[instr[19:15]], b);
            end
            7'b0010011: begin
                legal = (f3 == 3'd1) ? f7 == 7'h00
                    : (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
                alt = f3 == 3'd5 && f7[5];
                b = {{20{instr[31]}}, instr[31:20]};
                res = aluRef(f3, alt, modelRegs[instr[19:15]], b);
            end
            7'b0110111: begin
                legal = 1'b1;
                res = {instr[31:12], 12'b0};
            end
            7'b0010111: begin
                legal = 1'b1;
                res = pc + {instr[31:12], 12'b0};
            end
            default: ;
        endcase
        if (legal) begin
            return '{regNm: instr[11:7], value: res, pc: pc, illegal: 1'b0};
        end else begin
            return '{regNm: '0, value: '0, pc: pc, illegal: 1'b1};
        end
    endfunction

    // four-phase handshake for one instruction followed by a random idle gap
    task automatic sendInstr(input logic [31:0] instr);
        CorePkg::CommitPacket exp;
        logic [31:0] gap;
        exp = modelExec(instr, pcNext);
        expectQ.push_back(exp);
        if (!exp.illegal && exp.regNm != '0) begin
            modelRegs[exp.regNm] = exp.value;
        end
        sentCount++;
        fetch = '{instr: instr, pc: pcNext};
        instrReq = 1'b1;
        pcNext = pcNext + 32'd4;
        @(negedge clk);
        while (instrAck !== 1'b1) begin
            @(negedge clk);
        end
        instrReq = 1'b0;
        @(negedge clk);
        compareBit("instrAck", instrAck, 1'b0);
        takeBits(2, gap);
        repeat (gap) @(negedge clk);
    endtask

    task automatic waitDrain();
        while (expectQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic testReset();
        repeat (ResetCycles) begin
            @(negedge clk);
            compareBit("instrAck", instrAck, 1'b0);
            compareBit("commitValid", commitValid, 1'b0);
        end
    endtask

    task automatic testIndependent();
        sendInstr(iType(12'h7ab, 5'd0, 3'd0, 5'd1));
        sendInstr(iType(12'hff3, 5'd0, 3'd0, 5'd2));
        sendInstr(uType(7'b0110111, 20'h80000, 5'd3));
        for (int f = 0; f < 8; f++) begin
            sendInstr(rType(7'h00, 5'd2, 5'd1, 3'(f), 5'(8 + f)));
        end
        sendInstr(rType(7'h20, 5'd2, 5'd1, 3'd0, 5'd16));
        sendInstr(rType(7'h20, 5'd2, 5'd1, 3'd5, 5'd17));
        sendInstr(rType(7'h00, 5'd1, 5'd3, 3'd5, 5'd18));
        sendInstr(rType(7'h20, 5'd1, 5'd3, 3'd5, 5'd19));
        // shifts need a small shamt while the rest use a negative immediate
        for (int f = 0; f < 8; f++) begin
            sendInstr(iType((f == 1) ? 12'h005 : (f == 5) ? 12'h007 : 12'h9c5,
                5'd3, 3'(f), 5'(20 + f)));
        end
        sendInstr(iType(12'h407, 5'd3, 3'd5, 5'd28));
        waitDrain();
    endtask

    task automatic testDependencies();
        sendInstr(iType(12'h000, 5'd0, 3'd0, 5'd10));
        repeat (6) sendInstr(iType(12'h003, 5'd10, 3'd0, 5'd10));
        sendInstr(rType(7'h00, 5'd10, 5'd10, 3'd0, 5'd11));
        sendInstr(rType(7'h20, 5'd1, 5'd11, 3'd0, 5'd12));
        sendInstr(rType(7'h00, 5'd10, 5'd12, 3'd1, 5'd13));
        waitDrain();
        // producers have all retired so sources come from the rename table
        sendInstr(rType(7'h00, 5'd11, 5'd13, 3'd4, 5'd14));
        sendInstr(iType(12'hfff, 5'd14, 3'd0, 5'd15));
        waitDrain();
    endtask

    task automatic testUpperAndZero();
        sendInstr(uType(7'b0110111, 20'habcde, 5'd20));
        sendInstr(uType(7'b0010111, 20'h12345, 5'd21));
        sendInstr(iType(12'h007, 5'd1, 3'd0, 5'd0));
        sendInstr(rType(7'h00, 5'd1, 5'd0, 3'd0, 5'd22));
        sendInstr(uType(7'b0110111, 20'hfffff, 5'd0));
        sendInstr(rType(7'h00, 5'd0, 5'd0, 3'd6, 5'd23));
        sendInstr(iType(12'h004, 5'd21, 3'd0, 5'd24));
        waitDrain();
    endtask

    task automatic testIllegal();
        // nonzero values in the registers that the illegal ops name as rd
        sendInstr(iType(12'h123, 5'd0, 3'd0, 5'd5));
        sendInstr(iType(12'hfaa, 5'd0, 3'd0, 5'd6));
        sendInstr(iType(12'h03c, 5'd0, 3'd0, 5'd7));
        sendInstr(32'h0000_0000);
        sendInstr(32'hffff_ffff);
        sendInstr(32'h0020_8063);
        sendInstr(rType(7'h01, 5'd2, 5'd1, 3'd0, 5'd5));
        sendInstr(iType(12'h401, 5'd1, 3'd1, 5'd6));
        sendInstr(rType(7'h20, 5'd2, 5'd1, 3'd4, 5'd7));
        // targets of the illegal ops must still hold their old values
        sendInstr(rType(7'h00, 5'd6, 5'd5, 3'd0, 5'd25));
        sendInstr(rType(7'h00, 5'd0, 5'd7, 3'd6, 5'd26));
        waitDrain();
    endtask

    task automatic testRandom();
        logic [31:0] kind;
        logic [31:0] regs;
        logic [31:0] f3;
        logic [31:0] alt;
        logic [31:0] imm;
        for (int n = 0; n < 40; n++) begin
            takeBits(3, kind);
            takeBits(9, regs);
            takeBits(3, f3);
            takeBits(1, alt);
            takeBits(20, imm);
            if (kind < 4) begin
                sendInstr(rType((alt[0] && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00,
                    {2'b0, regs[8:6]}, {2'b0, regs[5:3]}, f3[2:0], {2'b0, regs[2:0]}));
            end else if (kind < 6) begin
                if (f3 == 1) begin
                    imm[11:5] = 7'h00;
                end else if (f3 == 5) begin
                    imm[11:5] = alt[0] ? 7'h20 : 7'h00;
                end
                sendInstr(iType(imm[11:0], {2'b0, regs[5:3]}, f3[2:0], {2'b0, regs[2:0]}));
            end else begin
                sendInstr(uType((kind == 6) ? 7'b0110111 : 7'b0010111, imm[19:0],
                    {2'b0, regs[2:0]}));
            end
        end
        waitDrain();
    endtask

    // commit monitor pops one expected commit per commitValid cycle
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && commitValid) begin
                if (expectQ.size() == 0) begin
                    failRun("a commit arrived with no instruction outstanding");
                end else begin
                    compareCommit(commit, expectQ.pop_front());
                end
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * ResetCycles + CyclesPerInstr * (sentCount + 1)) begin
                failRun("watchdog expired before the DUT finished the tests");
            end
        end
    end

    initial begin
        fetch = '0;
        instrReq = 1'b0;
        rst = 1'b1;
        lfsr = 32'hdc8d;
        pcNext = 32'h0000_1000;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
        testReset();
        testIndependent();
        testDependencies();
        testUpperAndZero();
        testIllegal();
        testRandom();
        repeat (8) @(negedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/CorePkg.sv
rtl/InstrDecoder.sv
rtl/RenameTable.sv
rtl/DecodeStage.sv
rtl/ReservationStation.sv
rtl/IntAlu.sv
rtl/ReorderBuffer.sv
rtl/OooCore.sv
bench/OooCoreTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module OooCoreTb -f verilog.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "=== PASS ===" || exit 1
